//--- source/fault_pkg.sv
/*
 * Stream fault detector shared definitions
 * Data, tag and address widths, register word indices and the
 * sticky fault flag encoding used by the control and datapath blocks
 */

package fault_pkg;

    // Width of one stream sample, of a register word and of every threshold
    localparam int data_width = 32;

    // Width of the destination tag carried by each stream beat
    localparam int dest_width = 8;

    // Byte address of the register bus, the word index sits in bits 7 to 2
    localparam int addr_width = 8;

    // Register word indices as seen on reg_addr[7:2]
    typedef enum logic [5:0] {
        // Signed lower bound of the slow window
        reg_slow_low      = 6'd0,
        // Signed upper bound of the slow window
        reg_slow_high     = 6'd1,
        // Bits 7 to 0 give the number of consecutive violations for a slow trip
        reg_trip_duration = 6'd2,
        // Signed lower bound of the fast window
        reg_fast_low      = 6'd3,
        // Signed upper bound of the fast window
        reg_fast_high     = 6'd4,
        // Read only, bit 1 is any fast fault and bit 0 is any slow fault
        reg_status        = 6'd5
    } reg_index_e;

    // Sticky state of one fault flag of one channel
    typedef enum logic {
        fault_clear   = 1'b0,
        fault_latched = 1'b1
    } fault_state_e;

endpackage

//--- source/fault_control.sv
/*
 * Fault detector control block
 * Holds the threshold register bank behind the strobe bus, answers
 * reads one cycle later and keeps the sticky fast and slow fault flags
 */

`timescale 1ns/1ns

module fault_control
    import fault_pkg::*;
#(
    parameter int N_CHANNELS = 4
) (
    input  logic                         clock,
    input  logic                         arst_n,
    input  logic                         reg_write,
    input  logic                         reg_read,
    input  logic [addr_width-1:0]        reg_addr,
    input  logic [data_width-1:0]        reg_wdata,
    output logic [data_width-1:0]        reg_rdata,
    output logic                         reg_rvalid,
    input  logic [N_CHANNELS-1:0]        fast_trip,
    input  logic [N_CHANNELS-1:0]        slow_trip,
    input  logic                         clear_fault,
    output logic signed [data_width-1:0] fast_low,
    output logic signed [data_width-1:0] fast_high,
    output logic signed [data_width-1:0] slow_low,
    output logic signed [data_width-1:0] slow_high,
    output logic [7:0]                   trip_duration,
    output logic                         fault
);

    // Word index decoded from the byte address
    reg_index_e word_index;
    // Full duration word, only the low byte reaches the slow timer
    logic [data_width-1:0] duration_word;
    // Word selected for readback in the current cycle
    logic [data_width-1:0] read_word;
    // Sticky flags, one per channel for each fault kind
    fault_state_e fast_state [N_CHANNELS];
    fault_state_e slow_state [N_CHANNELS];
    logic any_fast;
    logic any_slow;

    assign word_index    = reg_index_e'(reg_addr[addr_width-1:2]);
    assign trip_duration = duration_word[7:0];

    // Register bank, the status word and unknown indices ignore writes
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            slow_low      <= '0;
            slow_high     <= '0;
            duration_word <= '0;
            fast_low      <= '0;
            fast_high     <= '0;
        end else if (reg_write) begin
            case (word_index)
                reg_slow_low:      slow_low      <= reg_wdata;
                reg_slow_high:     slow_high     <= reg_wdata;
                reg_trip_duration: duration_word <= reg_wdata;
                reg_fast_low:      fast_low      <= reg_wdata;
                reg_fast_high:     fast_high     <= reg_wdata;
                default: ;
            endcase
        end
    end

    // Readback mux, status carries the aggregate fault bits
    always_comb begin
        case (word_index)
            reg_slow_low:      read_word = slow_low;
            reg_slow_high:     read_word = slow_high;
            reg_trip_duration: read_word = duration_word;
            reg_fast_low:      read_word = fast_low;
            reg_fast_high:     read_word = fast_high;
            reg_status:        read_word = {{(data_width-2){1'b0}}, any_fast, any_slow};
            default:           read_word = '0;
        endcase
    end

    // Read data is answered on the cycle after the strobe
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            reg_rvalid <= 1'b0;
            reg_rdata  <= '0;
        end else begin
            reg_rvalid <= reg_read;
            if (reg_read) begin
                reg_rdata <= read_word;
            end
        end
    end

    // Sticky flags, a trip in the clearing cycle keeps its own flag set
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int ch = 0; ch < N_CHANNELS; ch++) begin
                fast_state[ch] <= fault_clear;
                slow_state[ch] <= fault_clear;
            end
        end else begin
            for (int ch = 0; ch < N_CHANNELS; ch++) begin
                if (fast_trip[ch]) begin
                    fast_state[ch] <= fault_latched;
                end else if (clear_fault) begin
                    fast_state[ch] <= fault_clear;
                end
                if (slow_trip[ch]) begin
                    slow_state[ch] <= fault_latched;
                end else if (clear_fault) begin
                    slow_state[ch] <= fault_clear;
                end
            end
        end
    end

    // Reduce the per channel flags to the two status bits
    always_comb begin
        any_fast = 1'b0;
        any_slow = 1'b0;
        for (int ch = 0; ch < N_CHANNELS; ch++) begin
            any_fast = any_fast | (fast_state[ch] == fault_latched);
            any_slow = any_slow | (slow_state[ch] == fault_latched);
        end
    end

    assign fault = any_fast | any_slow;

    // The bus never issues a read and a write in the same cycle
    assert property (@(posedge clock) disable iff (!arst_n) !(reg_write && reg_read));

endmodule

//--- source/stream_sampler.sv
/*
 * Stream beat sampler
 * Registers each beat and turns its destination tag into a one-hot
 * channel select, beats outside the channel range are dropped
 */

`timescale 1ns/1ns

module stream_sampler
    import fault_pkg::*;
#(
    parameter int N_CHANNELS    = 4,
    parameter int STARTING_DEST = 0
) (
    input  logic                         clock,
    input  logic                         arst_n,
    input  logic                         stream_valid,
    input  logic signed [data_width-1:0] stream_data,
    input  logic [dest_width-1:0]        stream_dest,
    output logic                         sample_valid,
    output logic signed [data_width-1:0] sample_value,
    output logic [N_CHANNELS-1:0]        channel_sel
);

    // Channel number relative to the first destination
    logic [dest_width-1:0] offset;
    logic                  in_range;

    assign offset = stream_dest - dest_width'(STARTING_DEST);

    // Compare as integers so a tag below the first destination cannot wrap in
    assign in_range = (int'(stream_dest) >= STARTING_DEST) &&
                      (int'(stream_dest) < STARTING_DEST + N_CHANNELS);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            sample_valid <= 1'b0;
            channel_sel  <= '0;
        end else begin
            sample_valid <= stream_valid && in_range;
            for (int ch = 0; ch < N_CHANNELS; ch++) begin
                channel_sel[ch] <= stream_valid && in_range && (offset == dest_width'(ch));
            end
        end
    end

    // Sample payload only matters while sample_valid is high
    always_ff @(posedge clock) begin
        if (stream_valid) begin
            sample_value <= stream_data;
        end
    end

    // Exactly one channel is selected with each valid sample and none otherwise
    assert property (@(posedge clock) disable iff (!arst_n)
        $onehot0(channel_sel) && (sample_valid == (|channel_sel)));

endmodule

//--- source/fast_window_check.sv
/*
 * Fast window check
 * Compares every sample against the signed fast thresholds and
 * registers a one-cycle trip pulse on the channel it belongs to
 */

`timescale 1ns/1ns

module fast_window_check
    import fault_pkg::*;
#(
    parameter int N_CHANNELS = 4
) (
    input  logic                         clock,
    input  logic                         arst_n,
    input  logic                         sample_valid,
    input  logic signed [data_width-1:0] sample_value,
    input  logic [N_CHANNELS-1:0]        channel_sel,
    input  logic signed [data_width-1:0] fast_low,
    input  logic signed [data_width-1:0] fast_high,
    output logic [N_CHANNELS-1:0]        fast_trip
);

    logic below_low;
    logic above_high;
    logic out_of_window;

    // Both operands are signed so the compare is two's complement
    assign below_low     = sample_value < fast_low;
    assign above_high    = sample_value > fast_high;
    assign out_of_window = below_low || above_high;

    // A single violating sample trips its channel on the next cycle
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            fast_trip <= '0;
        end else if (sample_valid && out_of_window) begin
            fast_trip <= channel_sel;
        end else begin
            fast_trip <= '0;
        end
    end

endmodule

//--- source/slow_trip_timer.sv
/*
 * Slow trip timer
 * Counts consecutive out-of-window samples per channel and pulses
 * a trip when the count reaches the programmed duration
 */

`timescale 1ns/1ns

module slow_trip_timer
    import fault_pkg::*;
#(
    parameter int N_CHANNELS = 4
) (
    input  logic                         clock,
    input  logic                         arst_n,
    input  logic                         sample_valid,
    input  logic signed [data_width-1:0] sample_value,
    input  logic [N_CHANNELS-1:0]        channel_sel,
    input  logic signed [data_width-1:0] slow_low,
    input  logic signed [data_width-1:0] slow_high,
    input  logic [7:0]                   trip_duration,
    output logic [N_CHANNELS-1:0]        slow_trip
);

    // Consecutive violation count of each channel
    logic [7:0] count [N_CHANNELS];
    logic       out_of_window;
    logic       trip_enabled;

    assign out_of_window = (sample_value < slow_low) || (sample_value > slow_high);

    // Zero duration disables tripping, the counters still follow the samples
    assign trip_enabled = trip_duration != 8'd0;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            slow_trip <= '0;
            for (int ch = 0; ch < N_CHANNELS; ch++) begin
                count[ch] <= 8'd0;
            end
        end else begin
            slow_trip <= '0;
            for (int ch = 0; ch < N_CHANNELS; ch++) begin
                // Only the channel that owns this sample moves
                if (sample_valid && channel_sel[ch]) begin
                    if (!out_of_window) begin
                        count[ch] <= 8'd0;
                    end else if (trip_enabled && (count[ch] + 8'd1 == trip_duration)) begin
                        // Run complete, trip and start counting afresh
                        slow_trip[ch] <= 1'b1;
                        count[ch]     <= 8'd0;
                    end else begin
                        count[ch] <= count[ch] + 8'd1;
                    end
                end
            end
        end
    end

    // With a steady non-zero duration a counter below it never reaches it
    for (genvar ch = 0; ch < N_CHANNELS; ch++) begin : g_count_check
        assert property (@(posedge clock) disable iff (!arst_n)
            (trip_enabled && $stable(trip_duration) && $past(count[ch] < trip_duration))
            |-> (count[ch] < trip_duration));
    end

endmodule

//--- source/stream_fault_detector.sv
/*
 * Stream fault detector top level
 * Ties the register control block to the sampler, the fast window
 * check and the slow trip timer for N_CHANNELS stream channels
 */

`timescale 1ns/1ns

module stream_fault_detector
    import fault_pkg::*;
#(
    parameter int N_CHANNELS    = 4,
    parameter int STARTING_DEST = 0
) (
    input  logic                         clock,
    input  logic                         arst_n,
    // Watched stream
    input  logic                         stream_valid,
    input  logic signed [data_width-1:0] stream_data,
    input  logic [dest_width-1:0]        stream_dest,
    // Register strobe bus
    input  logic                         reg_write,
    input  logic                         reg_read,
    input  logic [addr_width-1:0]        reg_addr,
    input  logic [data_width-1:0]        reg_wdata,
    output logic [data_width-1:0]        reg_rdata,
    output logic                         reg_rvalid,
    // Fault handling
    input  logic                         clear_fault,
    output logic                         fault
);

    // Thresholds from the register bank
    logic signed [data_width-1:0] fast_low;
    logic signed [data_width-1:0] fast_high;
    logic signed [data_width-1:0] slow_low;
    logic signed [data_width-1:0] slow_high;
    logic [7:0]                   trip_duration;

    // Registered beat and its channel
    logic                         sample_valid;
    logic signed [data_width-1:0] sample_value;
    logic [N_CHANNELS-1:0]        channel_sel;

    // Trip pulses into the sticky flags
    logic [N_CHANNELS-1:0]        fast_trip;
    logic [N_CHANNELS-1:0]        slow_trip;

    fault_control #(
        .N_CHANNELS(N_CHANNELS)
    ) i_fault_control (
        .clock(clock),
        .arst_n(arst_n),
        .reg_write(reg_write),
        .reg_read(reg_read),
        .reg_addr(reg_addr),
        .reg_wdata(reg_wdata),
        .reg_rdata(reg_rdata),
        .reg_rvalid(reg_rvalid),
        .fast_trip(fast_trip),
        .slow_trip(slow_trip),
        .clear_fault(clear_fault),
        .fast_low(fast_low),
        .fast_high(fast_high),
        .slow_low(slow_low),
        .slow_high(slow_high),
        .trip_duration(trip_duration),
        .fault(fault)
    );

    stream_sampler #(
        .N_CHANNELS(N_CHANNELS),
        .STARTING_DEST(STARTING_DEST)
    ) i_stream_sampler (
        .clock(clock),
        .arst_n(arst_n),
        .stream_valid(stream_valid),
        .stream_data(stream_data),
        .stream_dest(stream_dest),
        .sample_valid(sample_valid),
        .sample_value(sample_value),
        .channel_sel(channel_sel)
    );

    fast_window_check #(
        .N_CHANNELS(N_CHANNELS)
    ) i_fast_window_check (
        .clock(clock),
        .arst_n(arst_n),
        .sample_valid(sample_valid),
        .sample_value(sample_value),
        .channel_sel(channel_sel),
        .fast_low(fast_low),
        .fast_high(fast_high),
        .fast_trip(fast_trip)
    );

    slow_trip_timer #(
        .N_CHANNELS(N_CHANNELS)
    ) i_slow_trip_timer (
        .clock(clock),
        .arst_n(arst_n),
        .sample_valid(sample_valid),
        .sample_value(sample_value),
        .channel_sel(channel_sel),
        .slow_low(slow_low),
        .slow_high(slow_high),
        .trip_duration(trip_duration),
        .slow_trip(slow_trip)
    );

endmodule

//--- test/clock_gen.sv
/*
 * Testbench clock and reset source
 * Free running 10 ns clock with an active low reset held for the first cycles
 */

`timescale 1ns/1ns

module clock_gen #(
    parameter int half_period  = 5,
    parameter int reset_cycles = 16
) (
    output logic clock,
    output logic arst_n
);

    initial begin
        clock = 1'b0;
        forever #(half_period) clock = ~clock;
    end

    initial begin
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge clock);
        // Release on a falling edge so no flop sees it change with the clock
        @(negedge clock);
        arst_n = 1'b1;
    end

endmodule

//--- test/fault_detector_tb.sv
/*
 * Stream fault detector testbench
 * Directed and random stimulus against a cycle accurate reference model
 * of the register bank, the channel counters and the sticky fault flags
 */

`timescale 1ns/1ns

module fault_detector_tb
    import fault_pkg::*;
;

    localparam int n_channels  = 4;
    localparam int first_dest  = 2;
    localparam int rounds      = 8;
    localparam int round_beats = 300;
    // Reset, directed part and random rounds, each round with its register traffic
    localparam int test_cycles = 16 + 400 + rounds * (round_beats + 20);
    localparam int timeout_ns  = (test_cycles + 1000) * 10;

    logic                         clock;
    logic                         arst_n;
    logic                         stream_valid;
    logic signed [data_width-1:0] stream_data;
    logic [dest_width-1:0]        stream_dest;
    logic                         reg_write;
    logic                         reg_read;
    logic [addr_width-1:0]        reg_addr;
    logic [data_width-1:0]        reg_wdata;
    logic [data_width-1:0]        reg_rdata;
    logic                         reg_rvalid;
    logic                         clear_fault;
    logic                         fault;

    int errors = 0;
    int checks = 0;
    logic [31:0] rng_state = 32'hf6cd;

    // Reference state, updated on every rising edge from the inputs sampled there
    logic signed [31:0]    model_regs [5];
    logic [7:0]            slow_count [n_channels];
    logic [n_channels-1:0] fast_flag;
    logic [n_channels-1:0] slow_flag;
    // Trip pulses reach the flags two edges after the beat is taken
    logic [n_channels-1:0] fast_pipe1;
    logic [n_channels-1:0] fast_pipe2;
    logic [n_channels-1:0] slow_pipe1;
    logic [n_channels-1:0] slow_pipe2;
    logic                  exp_fault;
    logic                  exp_rvalid;
    logic [31:0]           exp_rdata;

    clock_gen i_clock_gen (
        .clock(clock),
        .arst_n(arst_n)
    );

    stream_fault_detector #(
        .N_CHANNELS(n_channels),
        .STARTING_DEST(first_dest)
    ) i_stream_fault_detector (
        .clock(clock),
        .arst_n(arst_n),
        .stream_valid(stream_valid),
        .stream_data(stream_data),
        .stream_dest(stream_dest),
        .reg_write(reg_write),
        .reg_read(reg_read),
        .reg_addr(reg_addr),
        .reg_wdata(reg_wdata),
        .reg_rdata(reg_rdata),
        .reg_rvalid(reg_rvalid),
        .clear_fault(clear_fault),
        .fault(fault)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] seed);
        logic [31:0] x;
        x = seed;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] random_word();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // Applies one accepted beat to its channel counter, returns {fast, slow} trips
    function automatic logic [1:0] beat_trips(input logic signed [31:0] value, input int ch);
        logic [7:0] next_count;
        logic [7:0] duration;
        logic       fast_hit;
        logic       slow_hit;
        duration = model_regs[2][7:0];
        fast_hit = (value < model_regs[3]) || (value > model_regs[4]);
        slow_hit = 1'b0;
        if ((value < model_regs[0]) || (value > model_regs[1])) begin
            next_count = slow_count[ch] + 8'd1;
            if ((duration != 8'd0) && (next_count == duration)) begin
                slow_hit       = 1'b1;
                slow_count[ch] = 8'd0;
            end else begin
                slow_count[ch] = next_count;
            end
        end else begin
            slow_count[ch] = 8'd0;
        end
        return {fast_hit, slow_hit};
    endfunction

    // Word the bus returns for a word index, status gives {any fast, any slow}
    function automatic logic [31:0] read_value(input logic [5:0] idx);
        if (idx < 6'd5) begin
            return model_regs[idx];
        end
        if (idx == 6'd5) begin
            return {30'd0, |fast_flag, |slow_flag};
        end
        return 32'd0;
    endfunction

    always @(posedge clock) begin : reference_model
        logic [1:0] trips;
        if (!arst_n) begin
            for (int i = 0; i < 5; i++) begin
                model_regs[i] = '0;
            end
            for (int ch = 0; ch < n_channels; ch++) begin
                slow_count[ch] = 8'd0;
            end
            fast_flag  = '0;
            slow_flag  = '0;
            fast_pipe1 = '0;
            fast_pipe2 = '0;
            slow_pipe1 = '0;
            slow_pipe2 = '0;
            exp_fault  = 1'b0;
            exp_rvalid = 1'b0;
            exp_rdata  = '0;
        end else begin
            // Readback sees the state from before this edge
            exp_rvalid = reg_read;
            if (reg_read) begin
                exp_rdata = read_value(reg_addr[7:2]);
            end
            // A trip landing with clear_fault keeps its own flag
            fast_flag = fast_pipe2 | (clear_fault ? '0 : fast_flag);
            slow_flag = slow_pipe2 | (clear_fault ? '0 : slow_flag);
            fast_pipe2 = fast_pipe1;
            slow_pipe2 = slow_pipe1;
            fast_pipe1 = '0;
            slow_pipe1 = '0;
            if (reg_write && (reg_addr[7:2] < 6'd5)) begin
                model_regs[reg_addr[7:2]] = reg_wdata;
            end
            // The beat is judged against thresholds that include this edge's write
            if (stream_valid && (int'(stream_dest) >= first_dest) &&
                (int'(stream_dest) < first_dest + n_channels)) begin
                trips = beat_trips(stream_data, int'(stream_dest) - first_dest);
                fast_pipe1[int'(stream_dest) - first_dest] = trips[1];
                slow_pipe1[int'(stream_dest) - first_dest] = trips[0];
            end
            exp_fault = (|fast_flag) | (|slow_flag);
        end
    end

    // Outputs are settled half a cycle after the edge that the model mirrors
    always @(negedge clock) begin : compare
        if (arst_n) begin
            checks++;
            assert (fault === exp_fault) else begin
                errors++;
                $display("[FAIL] %0t fault is %b, model expects %b", $time, fault, exp_fault);
            end
            assert (reg_rvalid === exp_rvalid) else begin
                errors++;
                $display("[FAIL] %0t reg_rvalid is %b, model expects %b",
                         $time, reg_rvalid, exp_rvalid);
            end
            if (exp_rvalid) begin
                assert (reg_rdata === exp_rdata) else begin
                    errors++;
                    $display("[FAIL] %0t reg_rdata is %h, model expects %h",
                             $time, reg_rdata, exp_rdata);
                end
            end
        end
    end

    task automatic drive_cycle(input logic valid, input logic signed [31:0] data,
                               input logic [7:0] dest, input logic wr, input logic rd,
                               input logic [5:0] idx, input logic [31:0] wdata,
                               input logic clr);
        @(posedge clock);
        stream_valid <= valid;
        stream_data  <= data;
        stream_dest  <= dest;
        reg_write    <= wr;
        reg_read     <= rd;
        reg_addr     <= {idx, 2'b00};
        reg_wdata    <= wdata;
        clear_fault  <= clr;
    endtask

    task automatic send_beat(input logic signed [31:0] data, input logic [7:0] dest);
        drive_cycle(1'b1, data, dest, 1'b0, 1'b0, 6'd0, 32'd0, 1'b0);
    endtask

    task automatic write_reg(input logic [5:0] idx, input logic [31:0] data);
        drive_cycle(1'b0, 32'sd0, 8'd0, 1'b1, 1'b0, idx, data, 1'b0);
    endtask

    task automatic read_reg(input logic [5:0] idx);
        drive_cycle(1'b0, 32'sd0, 8'd0, 1'b0, 1'b1, idx, 32'd0, 1'b0);
    endtask

    task automatic pulse_clear();
        drive_cycle(1'b0, 32'sd0, 8'd0, 1'b0, 1'b0, 6'd0, 32'd0, 1'b1);
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) drive_cycle(1'b0, 32'sd0, 8'd0, 1'b0, 1'b0, 6'd0, 32'd0, 1'b0);
    endtask

    task automatic set_windows(input int slow_lim, input int fast_lim, input int duration);
        write_reg(6'd0, 32'(-slow_lim));
        write_reg(6'd1, 32'(slow_lim));
        write_reg(6'd2, 32'(duration));
        write_reg(6'd3, 32'(-fast_lim));
        write_reg(6'd4, 32'(fast_lim));
    endtask

    // An in-window beat on every channel brings all counters back to zero
    task automatic flush_counters();
        for (int ch = 0; ch < n_channels; ch++) begin
            send_beat(32'sd0, 8'(first_dest + ch));
        end
    endtask

    // Fixed expectation, independent of the model
    task automatic expect_fault(input logic want, input string what);
        @(negedge clock);
        checks++;
        assert (fault === want) else begin
            errors++;
            $display("[FAIL] %0t fault is %b after %s, expected %b", $time, fault, what, want);
        end
    endtask

    initial begin : stimulus
        logic [31:0] r;
        stream_valid = 1'b0;
        stream_data  = '0;
        stream_dest  = '0;
        reg_write    = 1'b0;
        reg_read     = 1'b0;
        reg_addr     = '0;
        reg_wdata    = '0;
        clear_fault  = 1'b0;
        @(posedge arst_n);

        // Register bank readback, status write ignored, unknown indices read zero
        set_windows(500, 2000, 32'h0000_a503);
        write_reg(6'd5, 32'hffff_ffff);
        for (int i = 0; i < 8; i++) begin
            read_reg(6'(i));
        end
        read_reg(6'd63);
        idle(2);

        // A single fast violation
        set_windows(1000, 100, 0);
        send_beat(32'sd150, 8'(first_dest));
        idle(3);
        expect_fault(1'b1, "a fast violation");
        read_reg(6'd5);

        // Slow run with a restart in the middle, then a tripping run
        pulse_clear();
        set_windows(50, 10000, 3);
        flush_counters();
        idle(3);
        expect_fault(1'b0, "clear_fault");
        send_beat(32'sd60, 8'(first_dest + 1));
        send_beat(32'sd70, 8'(first_dest + 1));
        send_beat(32'sd0, 8'(first_dest + 1));
        send_beat(-32'sd60, 8'(first_dest + 1));
        send_beat(32'sd70, 8'(first_dest + 1));
        idle(4);
        expect_fault(1'b0, "an interrupted slow run");
        send_beat(32'sd80, 8'(first_dest + 1));
        idle(4);
        expect_fault(1'b1, "a full slow run");
        read_reg(6'd5);

        // Zero duration never trips, even once the 8-bit counter wraps past zero
        pulse_clear();
        write_reg(6'd2, 32'd0);
        repeat (260) send_beat(32'sd60, 8'(first_dest + 2));
        idle(4);
        expect_fault(1'b0, "a slow run with zero duration");

        // Destinations outside the channel range are ignored
        set_windows(50, 100, 2);
        flush_counters();
        send_beat(32'sd99999, 8'd0);
        send_beat(32'sd99999, 8'(first_dest - 1));
        send_beat(32'sd99999, 8'(first_dest + n_channels));
        send_beat(-32'sd99999, 8'd200);
        idle(4);
        expect_fault(1'b0, "beats outside the channel range");

        // Interleaved channels keep their own counts
        set_windows(50, 10000, 2);
        send_beat(32'sd60, 8'(first_dest));
        send_beat(32'sd60, 8'(first_dest + 1));
        send_beat(32'sd0, 8'(first_dest + 1));
        idle(4);
        expect_fault(1'b0, "interleaved single violations");
        send_beat(32'sd60, 8'(first_dest));
        idle(4);
        expect_fault(1'b1, "a second violation on one channel");

        // Clear drops fault, then a trip landing with the clear keeps its flag
        pulse_clear();
        expect_fault(1'b1, "the clear strobe cycle");
        expect_fault(1'b0, "clear_fault");
        write_reg(6'd3, -32'sd100);
        write_reg(6'd4, 32'sd100);
        send_beat(32'sd500, 8'(first_dest + 3));
        idle(1);
        pulse_clear();
        idle(3);
        expect_fault(1'b1, "a trip in the clearing cycle");
        read_reg(6'd5);

        // Random thresholds and streams, the model checks every cycle
        for (int round = 0; round < rounds; round++) begin
            write_reg(6'd0, 32'd0 - (random_word() & 32'h0000_03ff));
            write_reg(6'd1, random_word() & 32'h0000_03ff);
            write_reg(6'd2, random_word() % 32'd6);
            write_reg(6'd3, 32'd0 - (random_word() & 32'h0000_07ff));
            write_reg(6'd4, random_word() & 32'h0000_07ff);
            for (int n = 0; n < round_beats; n++) begin
                r = random_word();
                case (r[4:0])
                    5'd0: pulse_clear();
                    5'd1: read_reg(6'd5);
                    5'd2: idle(1);
                    default: send_beat($signed(random_word() & 32'h0000_0fff) - 32'sd2048,
                                       8'(first_dest - 1 + int'(random_word() % 32'd6)));
                endcase
            end
            for (int i = 0; i < 6; i++) begin
                read_reg(6'(i));
            end
            idle(4);
        end

        idle(5);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin : watchdog
        #(timeout_ns);
        $display("Watchdog expired after %0d ns before the stimulus finished", timeout_ns);
        $display("Errors found");
        $finish;
    end

endmodule

//--- list.f
source/fault_pkg.sv
source/fault_control.sv
source/stream_sampler.sv
source/fast_window_check.sv
source/slow_trip_timer.sv
source/stream_fault_detector.sv
test/clock_gen.sv
test/fault_detector_tb.sv

//--- Makefile
# Verilator build and run of the stream fault detector testbench

SIM := obj_dir/Vfault_detector_tb

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): list.f $(wildcard source/*.sv test/*.sv)
	verilator --binary --timing --assert -j 0 --top-module fault_detector_tb \
		-Mdir obj_dir -f list.f

# Pass only when the log holds the pass line
run: $(SIM)
	$(SIM) | tee sim.log
	grep -qx "No errors" sim.log

clean:
	rm -rf obj_dir sim.log
